/* Makefile */
# Verilator build and run of the router output channel testbench

VERILATOR ?= verilator
TOP       ?= tbRouterOutputPort
SEED      ?= 27
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --assert --top-module $(TOP) -GlfsrSeed=$(SEED) \
	  --Mdir $(OBJ_DIR) -f sources.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)

/* include/router_config.svh */
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

`define ROUTER_FLIT_WIDTH 16  // one flit per cycle
`define ROUTER_LEN_WIDTH  12  // packet length field in head flit

`define ROUTER_NUM_PORTS  5   // L, N, E, W, S
`define ROUTER_FIFO_DEPTH 16  // must be a power of two

`endif

/* source/inputBuffer.sv */
`timescale 1ns/1ns
`include "router_config.svh"

module inputBuffer (
  input  logic            clk,
  input  logic            rst,
  input  logic            write,
  input  routerPkg::flitT inFlit,
  input  logic            pop,
  output routerPkg::flitT frontFlit,
  output logic            req,
  output logic            full
);

  localparam int ptrWidth = $clog2(`ROUTER_FIFO_DEPTH);
  localparam logic [ptrWidth:0] depthCount = `ROUTER_FIFO_DEPTH;

  routerPkg::flitT     mem [`ROUTER_FIFO_DEPTH];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0]   count;

  always_ff @(posedge clk)
  begin
    if (write)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (write)
      begin
        wrPtr <= wrPtr + 1'b1;  // wraps at depth
      end
      if (pop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({write, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  assign frontFlit = mem[rdPtr];  // oldest flit, no read latency
  assign req       = (count != '0);
  assign full      = (count == depthCount);

  // arbiter must only pop a port that is requesting
  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> req)
    else $error("inputBuffer: pop while empty");

  writeNotFull: assert property (@(posedge clk) disable iff (rst) write |-> !full)
    else $error("inputBuffer: write while full");

endmodule

/* source/outputStage.sv */
`timescale 1ns/1ns
`include "router_config.svh"

module outputStage (
  input  logic                         clk,
  input  logic                         rst,
  input  routerPkg::flitT              frontL,
  input  routerPkg::flitT              frontN,
  input  routerPkg::flitT              frontE,
  input  routerPkg::flitT              frontW,
  input  routerPkg::flitT              frontS,
  input  logic [`ROUTER_NUM_PORTS-1:0] pop,
  output logic                         outValid,
  output routerPkg::flitT              outFlit,
  output logic [2:0]                   outPort
);

  routerPkg::flitT fronts [`ROUTER_NUM_PORTS];
  routerPkg::flitT selFlit;
  logic [2:0]      selPort;

  assign fronts[0] = frontL;
  assign fronts[1] = frontN;
  assign fronts[2] = frontE;
  assign fronts[3] = frontW;
  assign fronts[4] = frontS;

  always_comb
  begin
    selFlit = fronts[0];
    selPort = '0;
    for (int i = 0; i < `ROUTER_NUM_PORTS; i++)
    begin
      if (pop[i])
      begin
        selFlit = fronts[i];
        selPort = 3'(i);  // one-hot to index
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |pop;
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;  // qualified by outValid
    outPort <= selPort;
  end

  popOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("outputStage: more than one port popped");

endmodule

/* source/packetTimer.sv */
`timescale 1ns/1ns
`include "router_config.svh"

module packetTimer (
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT frontFlit,
  input  logic            runTimer,
  output logic            timesUp
);

  logic [`ROUTER_LEN_WIDTH-1:0] pktLen;
  logic [`ROUTER_LEN_WIDTH-1:0] count;
  logic                         isHead;

  assign isHead = (frontFlit.head.kind == routerPkg::FLIT_HEAD);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLen <= '0;
      count  <= '0;
    end
    else if (runTimer)
    begin
      if (isHead)
      begin
        pktLen <= frontFlit.head.len;  // length latched on head pop
        count  <= {{(`ROUTER_LEN_WIDTH-1){1'b0}}, 1'b1};
      end
      else
      begin
        count <= count + 1'b1;
      end
    end
    else
    begin
      count <= '0;  // idle or granted elsewhere
    end
  end

  // high in the cycle after the last flit of the packet popped
  assign timesUp = (count != '0) && (count == pktLen);

  headLenNonZero: assert property (@(posedge clk) disable iff (rst)
    runTimer && isHead |-> frontFlit.head.len != '0)
    else $error("packetTimer: head popped with zero length");

endmodule

/* source/routerOutputPort.sv */
`timescale 1ns/1ns
`include "router_config.svh"

module routerOutputPort (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`ROUTER_NUM_PORTS-1:0] inWrite,
  input  routerPkg::flitT              inFlitL,
  input  routerPkg::flitT              inFlitN,
  input  routerPkg::flitT              inFlitE,
  input  routerPkg::flitT              inFlitW,
  input  routerPkg::flitT              inFlitS,
  output logic [`ROUTER_NUM_PORTS-1:0] inFull,
  output logic                         outValid,
  output routerPkg::flitT              outFlit,
  output logic [2:0]                   outPort
);

  routerPkg::flitT              frontL;
  routerPkg::flitT              frontN;
  routerPkg::flitT              frontE;
  routerPkg::flitT              frontW;
  routerPkg::flitT              frontS;
  logic [`ROUTER_NUM_PORTS-1:0] req;
  logic [`ROUTER_NUM_PORTS-1:0] pop;

  inputBuffer bufL (.clk(clk), .rst(rst), .write(inWrite[0]), .inFlit(inFlitL),
                    .pop(pop[0]), .frontFlit(frontL), .req(req[0]), .full(inFull[0]));
  inputBuffer bufN (.clk(clk), .rst(rst), .write(inWrite[1]), .inFlit(inFlitN),
                    .pop(pop[1]), .frontFlit(frontN), .req(req[1]), .full(inFull[1]));
  inputBuffer bufE (.clk(clk), .rst(rst), .write(inWrite[2]), .inFlit(inFlitE),
                    .pop(pop[2]), .frontFlit(frontE), .req(req[2]), .full(inFull[2]));
  inputBuffer bufW (.clk(clk), .rst(rst), .write(inWrite[3]), .inFlit(inFlitW),
                    .pop(pop[3]), .frontFlit(frontW), .req(req[3]), .full(inFull[3]));
  inputBuffer bufS (.clk(clk), .rst(rst), .write(inWrite[4]), .inFlit(inFlitS),
                    .pop(pop[4]), .frontFlit(frontS), .req(req[4]), .full(inFull[4]));

  switchArbiter arb (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .frontL (frontL),
    .frontN (frontN),
    .frontE (frontE),
    .frontW (frontW),
    .frontS (frontS),
    .pop    (pop),
    .grant  ()  // pop already carries the grant
  );

  outputStage outStage (
    .clk      (clk),
    .rst      (rst),
    .frontL   (frontL),
    .frontN   (frontN),
    .frontE   (frontE),
    .frontW   (frontW),
    .frontS   (frontS),
    .pop      (pop),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

endmodule

/* source/routerPkg.sv */
`include "router_config.svh"

package routerPkg;

  typedef enum logic [2:0] {
    FLIT_HEAD = 3'b001,
    FLIT_BODY = 3'b010,
    FLIT_TAIL = 3'b100
  } flitKindT;

  typedef enum logic [5:0] {
    ARB_IDLE  = 6'b000001,
    ARB_LOCAL = 6'b000010,
    ARB_NORTH = 6'b000100,
    ARB_EAST  = 6'b001000,
    ARB_WEST  = 6'b010000,
    ARB_SOUTH = 6'b100000
  } arbStateT;

  typedef struct packed {
    flitKindT                     kind;
    logic                         rsvd;
    logic [`ROUTER_LEN_WIDTH-1:0] len;   // counts the head itself
  } headViewT;

  typedef struct packed {
    flitKindT                      kind;
    logic [`ROUTER_FLIT_WIDTH-4:0] payload;
  } dataViewT;

  // same word, read as head or as body/tail
  typedef union packed {
    headViewT head;
    dataViewT data;
  } flitT;

endpackage

/* source/switchArbiter.sv */
`timescale 1ns/1ns
`include "router_config.svh"

module switchArbiter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [`ROUTER_NUM_PORTS-1:0] req,
  input  routerPkg::flitT              frontL,
  input  routerPkg::flitT              frontN,
  input  routerPkg::flitT              frontE,
  input  routerPkg::flitT              frontW,
  input  routerPkg::flitT              frontS,
  output logic [`ROUTER_NUM_PORTS-1:0] pop,
  output logic [`ROUTER_NUM_PORTS-1:0] grant
);

  routerPkg::arbStateT          state;
  routerPkg::arbStateT          nextState;
  logic [`ROUTER_NUM_PORTS-1:0] timesUp;

  // first requester in rotating order beginning at startIdx
  function automatic routerPkg::arbStateT rotate(
    input logic [`ROUTER_NUM_PORTS-1:0] r,
    input int                           startIdx
  );
    logic [5:0] code;
    int         idx;
    code = routerPkg::ARB_IDLE;
    for (int k = `ROUTER_NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (startIdx + k) % `ROUTER_NUM_PORTS;
      if (r[idx])
      begin
        code = 6'b000010 << idx;  // nearest one wins, it is written last
      end
    end
    return routerPkg::arbStateT'(code);
  endfunction

  packetTimer timerL (.clk(clk), .rst(rst), .frontFlit(frontL), .runTimer(pop[0]),
                      .timesUp(timesUp[0]));
  packetTimer timerN (.clk(clk), .rst(rst), .frontFlit(frontN), .runTimer(pop[1]),
                      .timesUp(timesUp[1]));
  packetTimer timerE (.clk(clk), .rst(rst), .frontFlit(frontE), .runTimer(pop[2]),
                      .timesUp(timesUp[2]));
  packetTimer timerW (.clk(clk), .rst(rst), .frontFlit(frontW), .runTimer(pop[3]),
                      .timesUp(timesUp[3]));
  packetTimer timerS (.clk(clk), .rst(rst), .frontFlit(frontS), .runTimer(pop[4]),
                      .timesUp(timesUp[4]));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= routerPkg::ARB_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state[5:1];
  assign pop   = grant & req & ~timesUp;  // pop also means "hold this port"

  // current port is masked out when rotating away
  always_comb
  begin
    unique case (state)
      routerPkg::ARB_IDLE:  nextState = rotate(req, 0);
      routerPkg::ARB_LOCAL: nextState = pop[0] ? state : rotate(req & 5'b11110, 1);
      routerPkg::ARB_NORTH: nextState = pop[1] ? state : rotate(req & 5'b11101, 2);
      routerPkg::ARB_EAST:  nextState = pop[2] ? state : rotate(req & 5'b11011, 3);
      routerPkg::ARB_WEST:  nextState = pop[3] ? state : rotate(req & 5'b10111, 4);
      routerPkg::ARB_SOUTH: nextState = pop[4] ? state : rotate(req & 5'b01111, 0);
      default:              nextState = routerPkg::ARB_IDLE;
    endcase
  end

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("switchArbiter: state not one-hot");

endmodule

/* sources.f */
+incdir+include
source/routerPkg.sv
source/inputBuffer.sv
source/packetTimer.sv
source/switchArbiter.sv
source/outputStage.sv
source/routerOutputPort.sv
tb/tbRouterOutputPort.sv

/* tb/tbRouterOutputPort.sv */
`timescale 1ns/1ns
`include "router_config.svh"

module tbRouterOutputPort #(
  parameter logic [15:0] lfsrSeed = 16'd27
);

  localparam int numPorts      = `ROUTER_NUM_PORTS;
  localparam int resetCycles   = 10;
  localparam int numRandomPkts = 120;
  localparam int numRefillPkts = 12;
  localparam int totalPkts     = numRandomPkts + numPorts + numRefillPkts;
  localparam int clkPeriod     = 40;
  localparam int timeLimit     = (totalPkts * 12 + 400) * clkPeriod;  // 400 cycles margin

  logic                clk = 1'b0;
  logic                rst;
  logic [numPorts-1:0] inWrite;
  routerPkg::flitT     inFlitL;
  routerPkg::flitT     inFlitN;
  routerPkg::flitT     inFlitE;
  routerPkg::flitT     inFlitW;
  routerPkg::flitT     inFlitS;
  logic [numPorts-1:0] inFull;
  logic                outValid;
  routerPkg::flitT     outFlit;
  logic [2:0]          outPort;

  logic [15:0]     lfsr;
  int              cycle = 0;
  routerPkg::flitT modelQ [numPorts][$];  // written, not yet seen at the output
  int              wrLen [numPorts];      // nonzero while a packet is being written
  int              wrIdx [numPorts];
  int              headCycle [$];
  int              headPort [$];
  int              curPort   = 0;         // source of the packet being emitted
  int              flitsLeft = 0;
  logic            prevValid = 1'b0;

  routerOutputPort uut (
    .clk      (clk),
    .rst      (rst),
    .inWrite  (inWrite),
    .inFlitL  (inFlitL),
    .inFlitN  (inFlitN),
    .inFlitE  (inFlitE),
    .inFlitW  (inFlitW),
    .inFlitS  (inFlitS),
    .inFull   (inFull),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

  always #(clkPeriod / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // x^16 + x^14 + x^13 + x^11
  function automatic logic nextBit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] randomBits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[14:0], nextBit()};
    end
    return v;
  endfunction

  function automatic routerPkg::flitT makeFlit(input int idx, input int len);
    routerPkg::flitT f;
    if (idx == 0)
    begin
      f.head.kind = routerPkg::FLIT_HEAD;
      f.head.rsvd = 1'b0;
      f.head.len  = 12'(len);
    end
    else
    begin
      f.data.kind    = (idx == len - 1) ? routerPkg::FLIT_TAIL : routerPkg::FLIT_BODY;
      f.data.payload = 13'(randomBits(13));
    end
    return f;
  endfunction

  function automatic logic allIdle();
    logic idle;
    idle = 1'b1;
    for (int p = 0; p < numPorts; p++)
    begin
      if (wrLen[p] != 0 || modelQ[p].size() != 0)
      begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task stopOnError();
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // next flit of every packet in flight, called right after a rising edge
  task driveEdge();
    logic [numPorts-1:0] wr;
    routerPkg::flitT     nf [numPorts];
    wr = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      nf[p] = '0;
      if (wrLen[p] != 0)
      begin
        nf[p] = makeFlit(wrIdx[p], wrLen[p]);
        modelQ[p].push_back(nf[p]);
        wr[p] = 1'b1;
        wrIdx[p]++;
        if (wrIdx[p] == wrLen[p])
        begin
          wrLen[p] = 0;
          wrIdx[p] = 0;
        end
      end
    end
    inWrite <= wr;
    inFlitL <= nf[0];
    inFlitN <= nf[1];
    inFlitE <= nf[2];
    inFlitW <= nf[3];
    inFlitS <= nf[4];
  endtask

  task idleEdges(input int n);
    repeat (n)
    begin
      @(posedge clk);
      driveEdge();
    end
  endtask

  task drain();
    do
    begin
      @(posedge clk);
      driveEdge();
    end
    while (!allIdle());
    idleEdges(4);  // arbiter settles back to idle
  endtask

  always @(negedge clk)
  begin
    int              port;
    routerPkg::flitT expected;
    if (cycle <= resetCycles + 2)
    begin
      assert (!outValid && inFull == '0)
      else
      begin
        $display("mismatch outValid/inFull around reset: got 0x%h/0x%h expected 0x0/0x00",
                 outValid, inFull);
        stopOnError();
      end
    end
    else if (outValid)
    begin
      port = int'(outPort);
      assert (port < numPorts)
      else
      begin
        $display("mismatch outPort: got 0x%h, beyond the last port 0x%h", outPort,
                 numPorts - 1);
        stopOnError();
      end
      assert (modelQ[port].size() > 0)
      else
      begin
        $display("flit came out of port %0d but nothing was written there", port);
        stopOnError();
      end
      expected = modelQ[port].pop_front();
      assert (outFlit == expected)
      else
      begin
        $display("mismatch outFlit: got 0x%h expected 0x%h (port %0d)", outFlit, expected, port);
        stopOnError();
      end
      if (expected.head.kind == routerPkg::FLIT_HEAD)
      begin
        assert (!prevValid)
        else
        begin
          $display("packet head at cycle %0d without an idle cycle before it", cycle);
          stopOnError();
        end
        assert (flitsLeft == 0)
        else
        begin
          $display("new packet started with %0d flits of port %0d still due", flitsLeft, curPort);
          stopOnError();
        end
        curPort   = port;
        flitsLeft = int'(expected.head.len) - 1;
        headCycle.push_back(cycle);
        headPort.push_back(port);
      end
      else
      begin
        assert (flitsLeft > 0)
        else
        begin
          $display("body flit from port %0d arrived with no packet open", port);
          stopOnError();
        end
        assert (port == curPort)
        else
        begin
          $display("mismatch outPort: got 0x%h expected 0x%h", outPort, curPort);
          stopOnError();
        end
        flitsLeft--;
      end
    end
    prevValid = outValid;
  end

  initial
  begin
    #(timeLimit);
    $display("timeout: the run did not finish within %0d ns", timeLimit);
    stopOnError();
  end

  initial
  begin
    int len;
    int started;
    int port;
    int dirStart;
    lfsr    = lfsrSeed;
    rst     = 1'b1;
    inWrite = '0;
    inFlitL = '0;
    inFlitN = '0;
    inFlitE = '0;
    inFlitW = '0;
    inFlitS = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      wrLen[p] = 0;
      wrIdx[p] = 0;
    end
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
    idleEdges(3);

    // random interleaved packets on all ports
    started = 0;
    while (started < numRandomPkts)
    begin
      @(posedge clk);
      for (int p = 0; p < numPorts; p++)
      begin
        if (wrLen[p] == 0 && started < numRandomPkts && randomBits(2) == 16'd0)
        begin
          len = int'(randomBits(3)) + 1;
          if (modelQ[p].size() + len <= `ROUTER_FIFO_DEPTH)
          begin
            wrLen[p] = len;
            started++;
          end
        end
      end
      driveEdge();
    end
    drain();

    // one length-3 packet per port, all heads in the same cycle
    @(posedge clk);
    headCycle.delete();
    headPort.delete();
    dirStart = cycle + 1;
    for (int p = 0; p < numPorts; p++)
    begin
      wrLen[p] = 3;
    end
    driveEdge();
    drain();
    assert (headPort.size() == numPorts)
    else
    begin
      $display("rotation test saw %0d packets instead of %0d", headPort.size(), numPorts);
      stopOnError();
    end
    for (int i = 0; i < numPorts; i++)
    begin
      assert (headPort[i] == i)
      else
      begin
        $display("mismatch outPort: got 0x%h expected 0x%h", headPort[i], i);
        stopOnError();
      end
      assert (headCycle[i] == dirStart + 3 + 4 * i)
      else
      begin
        $display("mismatch outValid: head at cycle 0x%h expected 0x%h", headCycle[i],
                 dirStart + 3 + 4 * i);
        stopOnError();
      end
    end

    // back-to-back packets on a single port
    port    = int'(randomBits(3)) % numPorts;
    started = 0;
    while (started < numRefillPkts)
    begin
      @(posedge clk);
      if (wrLen[port] == 0)
      begin
        len = int'(randomBits(3)) + 1;
        if (modelQ[port].size() + len <= `ROUTER_FIFO_DEPTH)
        begin
          wrLen[port] = len;
          started++;
        end
      end
      driveEdge();
    end
    drain();
    idleEdges(10);

    assert (allIdle() && flitsLeft == 0)
    else
    begin
      $display("flits still outstanding at the end of the run");
      stopOnError();
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule
